// File: shared_stack.f
stack_pkg.sv
arb_pkg.sv
stack_port_if.sv
lfsr.sv
synchronous_lifo.sv
stack_client_port.sv
stack_arbiter.sv
shared_stack_top.sv
tb_shared_stack.sv

// File: tb_shared_stack.sv
`timescale 1ns/10ps

module tb_shared_stack
  import stack_pkg::*;
();

  localparam int DEPTH          = 8;
  localparam int DATA_W         = 32;
  localparam int CW             = CNT_W(DEPTH);
  localparam int N_OPS          = 29;
  localparam int TIMEOUT_CYCLES = 20 * N_OPS + 50;
  localparam logic [31:0] SEED  = 32'd27742;

  // table operation codes
  localparam logic [1:0] T_PUSH     = 2'd0;
  localparam logic [1:0] T_POP      = 2'd1;
  localparam logic [1:0] T_POP_BOTH = 2'd2;

  typedef struct packed {
    logic              client;
    logic [1:0]        op;
    logic [DATA_W-1:0] data;
  } op_entry_t;

  logic              clk;
  logic              nrst;
  logic              push_0;
  logic              pop_0;
  logic              push_1;
  logic              pop_1;
  logic [DATA_W-1:0] wdata_0;
  logic [DATA_W-1:0] wdata_1;
  logic              busy_0;
  logic              busy_1;
  logic              rd_valid_0;
  logic              rd_valid_1;
  logic [DATA_W-1:0] rdata_0;
  logic [DATA_W-1:0] rdata_1;
  logic [CW-1:0]     cnt;
  logic              empty;
  logic              full;

  op_entry_t         op_table [N_OPS];
  int                n_built;
  logic [31:0]       rng_state;
  // reference stack and round-robin state
  logic [DATA_W-1:0] model_q [$];
  int                last_served;
  // responses seen during one entry
  int                got_client [4];
  logic [DATA_W-1:0] got_data [4];
  int                n_got;
  int                cycle_cnt = 0;

  shared_stack_top #(.DEPTH(DEPTH), .DATA_W(DATA_W)) uut (
    .clk        (clk),
    .nrst       (nrst),
    .push_0     (push_0),
    .pop_0      (pop_0),
    .wdata_0    (wdata_0),
    .busy_0     (busy_0),
    .rdata_0    (rdata_0),
    .rd_valid_0 (rd_valid_0),
    .push_1     (push_1),
    .pop_1      (pop_1),
    .wdata_1    (wdata_1),
    .busy_1     (busy_1),
    .rdata_1    (rdata_1),
    .rd_valid_1 (rd_valid_1),
    .cnt        (cnt),
    .empty      (empty),
    .full       (full)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic abort_run();
    $display("STATUS: FAIL");
    $fatal(1);
  endtask

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      abort_run();
    end
  endtask

  // guard against a hung handshake
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic add_entry(input logic client, input logic [1:0] op);
    rng_state = xorshift32(rng_state);
    op_table[n_built].client = client;
    op_table[n_built].op     = op;
    // top bit clear so pushed words never look like filler
    op_table[n_built].data   = rng_state & 32'h7fff_ffff;
    n_built++;
  endtask

  task automatic build_table();
    // client 0 push then pop in reverse
    repeat (3) add_entry(1'b0, T_PUSH);
    repeat (3) add_entry(1'b0, T_POP);
    // empty pops from both sides
    add_entry(1'b0, T_POP);
    add_entry(1'b1, T_POP);
    // fill, overflow, then pop the top
    repeat (9) add_entry(1'b0, T_PUSH);
    repeat (4) add_entry(1'b0, T_POP);
    // client 1 pushes and client 0 pops
    repeat (2) add_entry(1'b1, T_PUSH);
    repeat (2) add_entry(1'b0, T_POP);
    // ties after client 0 and after client 1 were served last
    add_entry(1'b0, T_POP_BOTH);
    add_entry(1'b1, T_POP);
    // the final tie finds the stack empty
    repeat (2) add_entry(1'b0, T_POP_BOTH);
  endtask

  task automatic model_push(input int client, input logic [DATA_W-1:0] data);
    if (model_q.size() < DEPTH) begin
      model_q.push_back(data);
    end
    last_served = client;
  endtask

  task automatic model_pop(input int client, output logic [DATA_W-1:0] data,
                           output logic filler);
    filler = (model_q.size() == 0);
    data   = '0;
    if (!filler) begin
      data = model_q.pop_back();
    end
    last_served = client;
  endtask

  task automatic check_pop_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                                input logic filler, input string what);
    if (filler) begin
      check_value(got[DATA_W-1], 1'b1, {what, " filler top bit"});
    end else begin
      check_value(got, exp, what);
    end
  endtask

  // sample at falling edges until both ports are idle
  task automatic collect_responses();
    n_got = 0;
    while (busy_0 || busy_1) begin
      if (rd_valid_0 && n_got < 4) begin
        got_client[n_got] = 0;
        got_data[n_got]   = rdata_0;
        n_got++;
      end
      if (rd_valid_1 && n_got < 4) begin
        got_client[n_got] = 1;
        got_data[n_got]   = rdata_1;
        n_got++;
      end
      @(negedge clk);
    end
  endtask

  task automatic run_entry(input int idx);
    op_entry_t         e;
    logic [DATA_W-1:0] exp0;
    logic [DATA_W-1:0] exp1;
    logic              fill0;
    logic              fill1;
    int                first;
    int                second;
    e = op_table[idx];
    // one-cycle strobe
    if (e.op == T_PUSH && !e.client) begin
      push_0  = 1'b1;
      wdata_0 = e.data;
    end else if (e.op == T_PUSH) begin
      push_1  = 1'b1;
      wdata_1 = e.data;
    end else if (e.op == T_POP) begin
      pop_0 = !e.client;
      pop_1 = e.client;
    end else begin
      pop_0 = 1'b1;
      pop_1 = 1'b1;
    end
    @(negedge clk);
    push_0 = 1'b0;
    push_1 = 1'b0;
    pop_0  = 1'b0;
    pop_1  = 1'b0;
    collect_responses();
    if (e.op == T_PUSH) begin
      model_push(e.client, e.data);
      check_value(n_got, 0, $sformatf("entry %0d rd_valid count on push", idx));
    end else if (e.op == T_POP) begin
      model_pop(e.client, exp0, fill0);
      check_value(n_got, 1, $sformatf("entry %0d rd_valid count", idx));
      check_value(got_client[0], e.client, $sformatf("entry %0d responding client", idx));
      check_pop_word(got_data[0], exp0, fill0, $sformatf("entry %0d pop data", idx));
    end else begin
      // the client not served last goes first
      first  = 1 - last_served;
      second = last_served;
      model_pop(first, exp0, fill0);
      model_pop(second, exp1, fill1);
      check_value(n_got, 2, $sformatf("entry %0d rd_valid count", idx));
      check_value(got_client[0], first, $sformatf("entry %0d first client", idx));
      check_value(got_client[1], second, $sformatf("entry %0d second client", idx));
      check_pop_word(got_data[0], exp0, fill0, $sformatf("entry %0d first data", idx));
      check_pop_word(got_data[1], exp1, fill1, $sformatf("entry %0d second data", idx));
    end
    check_value(cnt, model_q.size(), $sformatf("entry %0d cnt", idx));
    check_value(empty, model_q.size() == 0, $sformatf("entry %0d empty", idx));
    check_value(full, model_q.size() == DEPTH, $sformatf("entry %0d full", idx));
  endtask

  initial begin
    nrst        = 1'b0;
    push_0      = 1'b0;
    pop_0       = 1'b0;
    push_1      = 1'b0;
    pop_1       = 1'b0;
    wdata_0     = '0;
    wdata_1     = '0;
    rng_state   = SEED;
    n_built     = 0;
    last_served = 0;
    build_table();
    repeat (5) @(negedge clk);
    nrst = 1'b1;
    // idle window before the first strobe
    repeat (3) begin
      @(negedge clk);
      check_value(empty, 1'b1, "empty after reset");
      check_value(cnt, 0, "cnt after reset");
      check_value({busy_0, busy_1}, 2'b00, "busy after reset");
      check_value({rd_valid_0, rd_valid_1}, 2'b00, "rd_valid after reset");
    end
    for (int i = 0; i < N_OPS; i++) begin
      run_entry(i);
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// File: shared_stack_top.sv
`timescale 1ns/10ps

// shared stack for two requesters
// client ports, arbiter and lifo
module shared_stack_top
  import stack_pkg::*;
  import arb_pkg::*;
#(
  parameter int DEPTH  = 8,
  parameter int DATA_W = 32
) (
  input  logic                      clk,
  input  logic                      nrst,
  // client 0
  input  logic                      push_0,
  input  logic                      pop_0,
  input  logic [DATA_W-1:0]         wdata_0,
  output logic                      busy_0,
  output logic [DATA_W-1:0]         rdata_0,
  output logic                      rd_valid_0,
  // client 1
  input  logic                      push_1,
  input  logic                      pop_1,
  input  logic [DATA_W-1:0]         wdata_1,
  output logic                      busy_1,
  output logic [DATA_W-1:0]         rdata_1,
  output logic                      rd_valid_1,
  // shared flags
  output logic [CNT_W(DEPTH)-1:0]   cnt,
  output logic                      empty,
  output logic                      full
);

  // lifo request lines
  logic              w_req;
  logic              r_req;
  logic [DATA_W-1:0] w_data;
  logic [DATA_W-1:0] r_data;
  logic              lifo_busy;

  // one link per client
  stack_port_if #(.DATA_W(DATA_W)) port_if [N_CLIENTS] ();

  stack_client_port #(.DATA_W(DATA_W)) c0 (
    .clk      (clk),
    .nrst     (nrst),
    .push     (push_0),
    .pop      (pop_0),
    .wdata    (wdata_0),
    .busy     (busy_0),
    .rdata    (rdata_0),
    .rd_valid (rd_valid_0),
    .port     (port_if[0])
  );

  stack_client_port #(.DATA_W(DATA_W)) c1 (
    .clk      (clk),
    .nrst     (nrst),
    .push     (push_1),
    .pop      (pop_1),
    .wdata    (wdata_1),
    .busy     (busy_1),
    .rdata    (rdata_1),
    .rd_valid (rd_valid_1),
    .port     (port_if[1])
  );

  stack_arbiter #(.DATA_W(DATA_W)) arb (
    .clk    (clk),
    .nrst   (nrst),
    .port0  (port_if[0]),
    .port1  (port_if[1]),
    .w_req  (w_req),
    .r_req  (r_req),
    .w_data (w_data),
    .r_data (r_data),
    .busy   (lifo_busy),
    .empty  (empty),
    .full   (full)
  );

  synchronous_lifo #(.DEPTH(DEPTH), .DATA_W(DATA_W)) lifo (
    .clk    (clk),
    .nrst   (nrst),
    .w_req  (w_req),
    .w_data (w_data),
    .r_req  (r_req),
    .r_data (r_data),
    .cnt    (cnt),
    .empty  (empty),
    .full   (full),
    .busy   (lifo_busy)
  );

endmodule

// File: stack_arbiter.sv
`timescale 1ns/10ps

// round-robin access of two client ports to one lifo
// one operation at a time and pops take two extra cycles
module stack_arbiter
  import stack_pkg::*;
  import arb_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                nrst,
  stack_port_if.arbiter       port0,
  stack_port_if.arbiter       port1,
  // lifo side
  output logic                w_req,
  output logic                r_req,
  output logic [DATA_W-1:0]   w_data,
  input  logic [DATA_W-1:0]   r_data,
  input  logic                busy,
  input  logic                empty,
  input  logic                full
);

  stack_op_e         ops [N_CLIENTS];
  logic [DATA_W-1:0] wd  [N_CLIENTS];
  logic [N_CLIENTS-1:0] pend;
  logic [N_CLIENTS-1:0] done;
  logic [N_CLIENTS-1:0] valid;

  lifo_st_e    lifo_st;
  client_idx_t last_q;
  client_idx_t next_idx;
  client_idx_t sel;
  // wait_q marks the readout cycle of a pop in flight
  logic        wait_q;
  // ret_q marks its return cycle
  logic        ret_q;
  client_idx_t owner_q;

  logic        go;
  logic        is_push;
  logic        is_pop;
  logic        quick_done;
  logic        quick_valid;

  assign ops[0] = port0.op;
  assign ops[1] = port1.op;
  assign wd[0]  = port0.wdata;
  assign wd[1]  = port1.wdata;

  // lifo busy flag is its readout state
  assign lifo_st = lifo_st_e'(busy);

  always_comb begin
    for (int i = 0; i < N_CLIENTS; i++) begin
      pend[i] = (ops[i] != OP_NONE);
    end
  end

  // the client not served last wins a tie
  assign next_idx = last_q + 1'b1;
  assign sel      = pend[next_idx] ? next_idx : last_q;

  assign go      = !wait_q && !ret_q && (lifo_st == ST_IDLE) && pend[sel];
  assign is_push = (ops[sel] == OP_PUSH);
  assign is_pop  = (ops[sel] == OP_POP);

  // a push to a full stack completes without a strobe
  assign w_req  = go && is_push && !full;
  assign w_data = wd[sel];
  // empty pop is answered at once with the filler
  assign r_req  = go && is_pop && !empty;

  assign quick_done  = go && (is_push || (is_pop && empty));
  assign quick_valid = go && is_pop && empty;

  // response routing
  always_comb begin
    for (int i = 0; i < N_CLIENTS; i++) begin
      done[i]  = (quick_done && sel == client_idx_t'(i)) ||
                 (ret_q && owner_q == client_idx_t'(i));
      valid[i] = (quick_valid && sel == client_idx_t'(i)) ||
                 (ret_q && owner_q == client_idx_t'(i));
    end
  end

  assign port0.grant_done  = done[0];
  assign port1.grant_done  = done[1];
  assign port0.rdata_valid = valid[0];
  assign port1.rdata_valid = valid[1];
  assign port0.rdata       = r_data;
  assign port1.rdata       = r_data;

  always_ff @(posedge clk) begin
    if (!nrst) begin
      // client 0 counts as served so client 1 takes the first tie
      last_q  <= '0;
      owner_q <= '0;
      wait_q  <= 1'b0;
      ret_q   <= 1'b0;
    end else begin
      wait_q <= r_req;
      ret_q  <= wait_q;
      if (go) begin
        last_q <= sel;
      end
      if (r_req) begin
        owner_q <= sel;
      end
    end
  end

endmodule

// File: stack_client_port.sv
`timescale 1ns/10ps

// holds one pending push or pop for a requester
// further strobes are ignored until the held one is served
module stack_client_port
  import arb_pkg::*;
#(
  parameter int DATA_W = 32
) (
  input  logic                clk,
  input  logic                nrst,
  // requester side
  input  logic                push,
  input  logic                pop,
  input  logic [DATA_W-1:0]   wdata,
  output logic                busy,
  output logic [DATA_W-1:0]   rdata,
  output logic                rd_valid,
  // arbiter side
  stack_port_if.client        port
);

  stack_op_e         op_q;
  // push data, held with the request
  logic [DATA_W-1:0] wdata_q;
  // last popped word, kept after the pulse
  logic [DATA_W-1:0] rdata_q;
  logic              accept;

  // a new strobe only lands while nothing is pending
  assign accept = !busy && (push || pop);

  assign busy       = (op_q != OP_NONE);
  assign port.op    = op_q;
  assign port.wdata = wdata_q;

  // rd_valid lines up with the arbiter's return pulse
  assign rd_valid = port.rdata_valid;
  assign rdata    = port.rdata_valid ? port.rdata : rdata_q;

  // pending request
  always_ff @(posedge clk) begin
    if (!nrst) begin
      op_q <= OP_NONE;
    end else if (port.grant_done) begin
      // served, busy falls next cycle
      op_q <= OP_NONE;
    end else if (accept) begin
      // pop wins over push
      op_q <= pop ? OP_POP : OP_PUSH;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wdata_q <= wdata;
    end
  end

  // hold the returned word
  always_ff @(posedge clk) begin
    if (port.rdata_valid) begin
      rdata_q <= port.rdata;
    end
  end

endmodule

// File: synchronous_lifo.sv
`timescale 1ns/10ps

// single-clock stack with registered readout
// one write or one read request per idle cycle
module synchronous_lifo
  import stack_pkg::*;
#(
  parameter int DEPTH  = 8,
  parameter int DATA_W = 32
) (
  input  logic                      clk,
  input  logic                      nrst,
  // write port
  input  logic                      w_req,
  input  logic [DATA_W-1:0]         w_data,
  // read port
  input  logic                      r_req,
  output logic [DATA_W-1:0]         r_data,
  // helper flags
  output logic [CNT_W(DEPTH)-1:0]   cnt,
  output logic                      empty,
  output logic                      full,
  output logic                      busy
);

  localparam int CW     = CNT_W(DEPTH);
  localparam int ADDR_W = CW - 1;

  // storage, mem[cnt_q] is always the first free slot
  logic [DATA_W-1:0] mem [DEPTH];

  lifo_st_e          state_q;
  logic [CW-1:0]     cnt_q;
  // registered readout word
  logic [DATA_W-1:0] r_data_q;
  // high the cycle after a readout
  // keeps the popped word visible even if the stack just went empty
  logic              fresh_q;

  logic              wr_en;
  logic              rd_start;
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] top_addr;

  logic [30:0]       lfsr_state;
  logic [DATA_W-1:0] filler;

  assign empty = (cnt_q == '0);
  assign full  = (cnt_q == CW'(DEPTH));
  assign busy  = (state_q == ST_READOUT);
  assign cnt   = cnt_q;

  // writes only in idle, never past the last slot
  assign wr_en    = (state_q == ST_IDLE) && w_req && !full;
  // reading an empty stack starts no readout
  assign rd_start = (state_q == ST_IDLE) && r_req && !empty;

  assign wr_addr  = cnt_q[ADDR_W-1:0];
  // top word sits one below the free slot
  assign top_addr = ADDR_W'(cnt_q - 1'b1);

  // filler for empty reads
  // top bit set, low bits from the lfsr
  assign filler = {1'b1, {(DATA_W-1){1'b0}}} | DATA_W'(lfsr_state);

  assign r_data = (empty && !fresh_q) ? filler : r_data_q;

  // control state and element count
  always_ff @(posedge clk) begin
    if (!nrst) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
      fresh_q <= 1'b0;
    end else begin
      fresh_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (wr_en) begin
            cnt_q <= cnt_q + 1'b1;
          end
          if (rd_start) begin
            state_q <= ST_READOUT;
          end
        end
        ST_READOUT: begin
          // word leaves the stack here
          cnt_q   <= cnt_q - 1'b1;
          fresh_q <= 1'b1;
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // storage write
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= w_data;
    end
  end

  // output register, loaded once per readout
  always_ff @(posedge clk) begin
    if (state_q == ST_READOUT) begin
      r_data_q <= mem[top_addr];
    end
  end

  // filler source
  lfsr lfsr_inst (
    .clk   (clk),
    .nrst  (nrst),
    .state (lfsr_state)
  );

endmodule

// File: lfsr.sv
`timescale 1ns/10ps

// free-running 31-bit fibonacci lfsr
// polynomial x^31 + x^28 + 1, maximal length
// never reaches zero once seeded with ones
module lfsr (
  input  logic        clk,
  input  logic        nrst,
  output logic [30:0] state
);

  // feedback from taps 31 and 28
  logic fb;

  assign fb = state[30] ^ state[27];

  // steps every cycle, no enable
  always_ff @(posedge clk) begin
    if (!nrst) begin
      // all ones seed
      state <= '1;
    end else begin
      // shift toward msb, new bit enters at lsb
      state <= {state[29:0], fb};
    end
  end

endmodule

// File: stack_port_if.sv
`timescale 1ns/10ps

// one client's link to the arbiter
// the client holds op until grant_done, then drops it to none
interface stack_port_if
  import arb_pkg::*;
#(
  parameter int DATA_W = 32
);

  // request side, driven by the client port
  stack_op_e          op;
  logic [DATA_W-1:0]  wdata;

  // response side, driven by the arbiter
  // grant_done pulses once per served operation
  logic               grant_done;
  // popped word, qualified by rdata_valid
  logic [DATA_W-1:0]  rdata;
  logic               rdata_valid;

  modport client (
    output op,
    output wdata,
    input  grant_done,
    input  rdata,
    input  rdata_valid
  );

  modport arbiter (
    input  op,
    input  wdata,
    output grant_done,
    output rdata,
    output rdata_valid
  );

endinterface

// File: arb_pkg.sv
// definitions that describe the clients and their requests
package arb_pkg;

  // number of requesters sharing the stack
  localparam int N_CLIENTS = 2;

  // index of one client, also the last-served pointer
  typedef logic [$clog2(N_CLIENTS)-1:0] client_idx_t;

  // operation held by a client port while pending
  // none means no request is waiting
  typedef enum logic [1:0] {
    OP_NONE = 2'd0,
    OP_PUSH = 2'd1,
    OP_POP  = 2'd2
  } stack_op_e;

endpackage

// File: stack_pkg.sv
// definitions that describe the stack itself
package stack_pkg;

  // readout machine of the lifo
  // idle accepts writes and read requests,
  // readout moves the top word into the output register
  typedef enum logic {
    ST_IDLE    = 1'b0,
    ST_READOUT = 1'b1
  } lifo_st_e;

  // width of the element count for a given depth
  // one bit above the address width so cnt == depth fits
  // depth is expected to be a power of two
  function automatic int CNT_W(input int depth);
    int addr_w;
    addr_w = (depth > 1) ? $clog2(depth) : 1;
    return addr_w + 1;
  endfunction

endpackage
